/* build.f */
+incdir+include
hdl/csr_pkg.sv
hdl/csr_access.sv
hdl/trap_ctrl.sv
hdl/machine_csr_regs.sv
hdl/csr_file_top.sv
sim/tb_csr_file.sv

/* hdl/csr_access.sv */
`default_nettype none

module csr_access
    import csr_pkg::*;
#(
    parameter int unsigned HART_ID = 0
)
(
    input  csr_req_t        csr_req_i,
    input  mstatus_t        mstatus_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic [XLEN-1:0] mip_i,
    input  logic [XLEN-1:0] mscratch_i,
    input  logic [XLEN-1:0] mepc_i,
    input  logic [XLEN-1:0] mcause_i,
    input  logic [XLEN-1:0] mtval_i,
    input  mtvec_t          mtvec_i,
    input  logic [63:0]     mcycle_i,
    output logic [XLEN-1:0] rdata_o,
    output csr_wen_t        wen_o,
    output logic [XLEN-1:0] wdata_o
);

    // Second operand of the read-modify-write
    logic [XLEN-1:0] operand;
    // Request that modifies the addressed register
    logic            do_write;

    // ----------------------------------------
    // Read multiplexer
    // ----------------------------------------
    // Always returns the old value, also for reads with no write
    always_comb
    begin
        case (csr_req_i.addr)
            CSR_MSTATUS:  rdata_o = mstatus_i;
            CSR_MIE:      rdata_o = mie_i;
            CSR_MIP:      rdata_o = mip_i;
            CSR_MTVEC:    rdata_o = mtvec_i;
            CSR_MSCRATCH: rdata_o = mscratch_i;
            CSR_MEPC:     rdata_o = mepc_i;
            CSR_MCAUSE:   rdata_o = mcause_i;
            CSR_MTVAL:    rdata_o = mtval_i;
            // User cycle addresses alias the machine counter
            CSR_MCYCLE, CSR_CYCLE:   rdata_o = mcycle_i[31:0];
            CSR_MCYCLEH, CSR_CYCLEH: rdata_o = mcycle_i[63:32];
            // Non-commercial core, ID registers are zero
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID: rdata_o = '0;
            CSR_MHARTID:  rdata_o = XLEN'(HART_ID);
            default:      rdata_o = '0;
        endcase
    end

    // ----------------------------------------
    // Read-modify-write
    // ----------------------------------------
    // uimm is zero extended
    assign operand = csr_req_i.use_imm ? {{(XLEN-5){1'b0}}, csr_req_i.imm}
                                       : csr_req_i.rs1;

    always_comb
    begin
        case (csr_req_i.op)
            CSR_OP_WRITE: wdata_o = operand;
            CSR_OP_SET:   wdata_o = rdata_o | operand;
            CSR_OP_CLEAR: wdata_o = rdata_o & ~operand;
            default:      wdata_o = rdata_o;
        endcase
    end

    // ----------------------------------------
    // Write enable decode
    // ----------------------------------------
    assign do_write = csr_req_i.valid && (csr_req_i.op != CSR_OP_NONE);

    always_comb
    begin
        wen_o = '0;
        if (do_write)
        begin
            case (csr_req_i.addr)
                CSR_MSTATUS:  wen_o.mstatus   = 1'b1;
                CSR_MIE:      wen_o.mie       = 1'b1;
                CSR_MTVEC:    wen_o.mtvec     = 1'b1;
                CSR_MSCRATCH: wen_o.mscratch  = 1'b1;
                CSR_MEPC:     wen_o.mepc      = 1'b1;
                CSR_MCAUSE:   wen_o.mcause    = 1'b1;
                CSR_MTVAL:    wen_o.mtval     = 1'b1;
                CSR_MCYCLE:   wen_o.mcycle_lo = 1'b1;
                CSR_MCYCLEH:  wen_o.mcycle_hi = 1'b1;
                // mip, IDs, user cycle and unknown addresses drop the write
                default:      wen_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_file_top.sv */
`default_nettype none

module csr_file_top
    import csr_pkg::*;
#(
    parameter int unsigned HART_ID = 0
)
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  csr_req_t        csr_req_i,
    input  irq_lines_t      irq_i,
    input  exc_req_t        exc_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            mret_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic            trap_o,
    output logic [XLEN-1:0] trap_pc_o,
    output logic [XLEN-1:0] mret_pc_o,
    output priv_e           priv_o
);

    // Register state
    mstatus_t        mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    mtvec_t          mtvec;
    logic [63:0]     mcycle;
    priv_e           priv;
    // Access path into the registers
    csr_wen_t        csr_wen;
    logic [XLEN-1:0] csr_wdata;
    trap_evt_t       trap_evt;

    // ----------------------------------------
    // CSR read and write decode
    // ----------------------------------------
    csr_access #(
        .HART_ID    (HART_ID)
    ) i_csr_access (
        .csr_req_i  (csr_req_i),
        .mstatus_i  (mstatus),
        .mie_i      (mie),
        .mip_i      (mip),
        .mscratch_i (mscratch),
        .mepc_i     (mepc),
        .mcause_i   (mcause),
        .mtval_i    (mtval),
        .mtvec_i    (mtvec),
        .mcycle_i   (mcycle),
        .rdata_o    (csr_rdata_o),
        .wen_o      (csr_wen),
        .wdata_o    (csr_wdata)
    );

    // Trap decision and handler address
    trap_ctrl i_trap_ctrl (
        .exc_i      (exc_i),
        .irq_i      (irq_i),
        .mstatus_i  (mstatus),
        .mie_i      (mie),
        .mtvec_i    (mtvec),
        .priv_i     (priv),
        .trap_o     (trap_evt),
        .trap_pc_o  (trap_pc_o)
    );

    // Register storage, owns the update precedence
    machine_csr_regs i_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .trap_i     (trap_evt),
        .pc_i       (pc_i),
        .mret_i     (mret_i),
        .irq_i      (irq_i),
        .wen_i      (csr_wen),
        .wdata_i    (csr_wdata),
        .mstatus_o  (mstatus),
        .mie_o      (mie),
        .mip_o      (mip),
        .mscratch_o (mscratch),
        .mepc_o     (mepc),
        .mcause_o   (mcause),
        .mtval_o    (mtval),
        .mtvec_o    (mtvec),
        .mcycle_o   (mcycle),
        .priv_o     (priv)
    );

    assign trap_o    = trap_evt.take;
    // mret resumes at the saved PC
    assign mret_pc_o = mepc;
    assign priv_o    = priv;

endmodule

`default_nettype wire

/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    // RV32 data word
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // ----------------------------------------
    // CSR addresses
    // ----------------------------------------
    // Machine trap setup and handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;
    // Machine counters
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    // Machine information, read only
    localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hF14;
    // User view of the cycle counter, read only
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE     = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH    = 12'hC80;

    // Exception codes that load mtval
    // Misaligned and fault codes 0, 1, 4-7, 12, 13, 15
    localparam logic [15:0] TVAL_CAUSE_MASK = 16'hB0F3;

    // Machine interrupt codes, also the mie and mip bit positions
    localparam logic [3:0] IRQ_CODE_EXT = 4'd11;
    localparam logic [3:0] IRQ_CODE_TMR = 4'd7;
    localparam logic [3:0] IRQ_CODE_SFT = 4'd3;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    // Low two bits of funct3; 00 is a plain read
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    // Privilege levels kept, no supervisor
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef struct packed {
        logic                  valid;
        logic [CSR_ADDR_W-1:0] addr;
        csr_op_e               op;
        logic                  use_imm;
        logic [4:0]            imm;
        logic [XLEN-1:0]       rs1;
    } csr_req_t;

    typedef struct packed {
        logic ext;
        logic tmr;
        logic sft;
    } irq_lines_t;

    typedef struct packed {
        logic            valid;
        logic [3:0]      cause;
        logic [XLEN-1:0] tval;
    } exc_req_t;

    // mstatus bit layout, only MPP, MPIE and MIE are live
    typedef struct packed {
        logic [18:0] rsvd_31_13;
        priv_e       mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    // Base is word aligned, mode 1 is vectored
    typedef struct packed {
        logic [XLEN-3:0] base;
        logic [1:0]      mode;
    } mtvec_t;

    // One strobe per writable register
    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mcycle_lo;
        logic mcycle_hi;
    } csr_wen_t;

    // Trap decision handed to the register block
    typedef struct packed {
        logic            take;
        logic [XLEN-1:0] cause;
        logic            tval_we;
        logic [XLEN-1:0] tval;
    } trap_evt_t;

endpackage

`default_nettype wire

/* hdl/machine_csr_regs.sv */
`default_nettype none

module machine_csr_regs
    import csr_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  trap_evt_t       trap_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            mret_i,
    input  irq_lines_t      irq_i,
    input  csr_wen_t        wen_i,
    input  logic [XLEN-1:0] wdata_i,
    output mstatus_t        mstatus_o,
    output logic [XLEN-1:0] mie_o,
    output logic [XLEN-1:0] mip_o,
    output logic [XLEN-1:0] mscratch_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o,
    output logic [XLEN-1:0] mtval_o,
    output mtvec_t          mtvec_o,
    output logic [63:0]     mcycle_o,
    output priv_e           priv_o
);

    mstatus_t        mstatus_d;
    priv_e           priv_d;
    // Write data seen through the mstatus layout
    mstatus_t        wr_status;
    // CSR strobes left after trap and mret
    csr_wen_t        wen;
    // Raw lines placed at their mip bit positions
    logic [XLEN-1:0] irq_word;

    // ----------------------------------------
    // Precedence: trap, mret, CSR write
    // ----------------------------------------
    always_comb
    begin
        wen = wen_i;
        // Instruction at pc_i is replayed, so its write is dropped
        if (trap_i.take || mret_i)
            wen = '0;
    end

    assign wr_status = wdata_i;

    // mstatus and privilege next state
    always_comb
    begin
        mstatus_d = mstatus_o;
        priv_d    = priv_o;
        if (trap_i.take)
        begin
            // Stack MIE, remember where we came from
            mstatus_d.mpie = mstatus_o.mie;
            mstatus_d.mie  = 1'b0;
            mstatus_d.mpp  = priv_o;
            priv_d         = PRIV_M;
        end
        else if (mret_i)
        begin
            mstatus_d.mie  = mstatus_o.mpie;
            mstatus_d.mpie = 1'b1;
            mstatus_d.mpp  = PRIV_U;
            priv_d         = mstatus_o.mpp;
        end
        else if (wen.mstatus)
        begin
            // Only three fields exist, the rest stay zero
            mstatus_d      = '0;
            mstatus_d.mie  = wr_status.mie;
            mstatus_d.mpie = wr_status.mpie;
            // WARL: unsupported levels fold to User
            mstatus_d.mpp  = (wr_status.mpp == PRIV_M) ? PRIV_M : PRIV_U;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mstatus_o     <= '0;
            mstatus_o.mie <= 1'b1;
            mstatus_o.mpp <= PRIV_M;
            priv_o        <= PRIV_M;
        end
        else
        begin
            mstatus_o <= mstatus_d;
            priv_o    <= priv_d;
        end
    end

    // ----------------------------------------
    // Trap capture registers
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mepc_o   <= '0;
            mcause_o <= '0;
            mtval_o  <= '0;
        end
        else if (trap_i.take)
        begin
            mepc_o   <= pc_i;
            mcause_o <= trap_i.cause;
            if (trap_i.tval_we)
                mtval_o <= trap_i.tval;
        end
        else
        begin
            if (wen.mepc)
                mepc_o <= wdata_i;
            if (wen.mcause)
                mcause_o <= wdata_i;
            if (wen.mtval)
                mtval_o <= wdata_i;
        end
    end

    // ----------------------------------------
    // Software-only registers and mip
    // ----------------------------------------
    always_comb
    begin
        irq_word               = '0;
        irq_word[IRQ_CODE_EXT] = irq_i.ext;
        irq_word[IRQ_CODE_TMR] = irq_i.tmr;
        irq_word[IRQ_CODE_SFT] = irq_i.sft;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mie_o      <= '0;
            mip_o      <= '0;
            mtvec_o    <= '0;
            mscratch_o <= '0;
        end
        else
        begin
            // Pending view is masked by mie, one cycle behind the lines
            mip_o <= irq_word & mie_o;
            if (wen.mie)
                mie_o <= wdata_i;
            if (wen.mtvec)
                mtvec_o <= wdata_i;
            if (wen.mscratch)
                mscratch_o <= wdata_i;
        end
    end

    // Free-running cycle counter, a written edge does not count
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            mcycle_o <= '0;
        else if (wen.mcycle_lo)
            mcycle_o[31:0] <= wdata_i;
        else if (wen.mcycle_hi)
            mcycle_o[63:32] <= wdata_i;
        else
            mcycle_o <= mcycle_o + 64'd1;
    end

endmodule

`default_nettype wire

/* hdl/trap_ctrl.sv */
`default_nettype none

module trap_ctrl
    import csr_pkg::*;
(
    input  exc_req_t        exc_i,
    input  irq_lines_t      irq_i,
    input  mstatus_t        mstatus_i,
    input  logic [XLEN-1:0] mie_i,
    input  mtvec_t          mtvec_i,
    input  priv_e           priv_i,
    output trap_evt_t       trap_o,
    output logic [XLEN-1:0] trap_pc_o
);

    // mtvec mode for per-cause interrupt entry
    localparam logic [1:0] MTVEC_VECTORED = 2'd1;

    logic            irq_global_en;
    logic            irq_hit;
    logic [3:0]      irq_code;
    logic [XLEN-1:0] vec_base;

    // ----------------------------------------
    // Interrupt selection
    // ----------------------------------------
    // Lower privilege never masks M interrupts
    assign irq_global_en = (priv_i == PRIV_U) || mstatus_i.mie;

    // Fixed priority: external, then timer, then software
    always_comb
    begin
        irq_hit  = 1'b0;
        irq_code = IRQ_CODE_SFT;
        if (irq_i.ext && mie_i[IRQ_CODE_EXT])
        begin
            irq_hit  = 1'b1;
            irq_code = IRQ_CODE_EXT;
        end
        else if (irq_i.tmr && mie_i[IRQ_CODE_TMR])
        begin
            irq_hit  = 1'b1;
            irq_code = IRQ_CODE_TMR;
        end
        else if (irq_i.sft && mie_i[IRQ_CODE_SFT])
        begin
            irq_hit  = 1'b1;
            irq_code = IRQ_CODE_SFT;
        end
    end

    // ----------------------------------------
    // Trap event
    // ----------------------------------------
    always_comb
    begin
        trap_o.take    = 1'b0;
        trap_o.cause   = '0;
        trap_o.tval_we = 1'b0;
        trap_o.tval    = exc_i.tval;
        // Synchronous exceptions win over interrupts
        if (exc_i.valid)
        begin
            trap_o.take    = 1'b1;
            trap_o.cause   = {{(XLEN-4){1'b0}}, exc_i.cause};
            // Only address and fault codes carry a trap value
            trap_o.tval_we = TVAL_CAUSE_MASK[exc_i.cause];
        end
        else if (irq_hit && irq_global_en)
        begin
            // Interrupt flag in bit 31, mtval left alone
            trap_o.take  = 1'b1;
            trap_o.cause = {1'b1, {(XLEN-5){1'b0}}, irq_code};
        end
    end

    // ----------------------------------------
    // Handler address
    // ----------------------------------------
    assign vec_base = {mtvec_i.base, 2'b00};

    always_comb
    begin
        // Vectored entry only for interrupts, base + 4 * code
        if (mtvec_i.mode == MTVEC_VECTORED && trap_o.cause[XLEN-1])
            trap_pc_o = vec_base + {{(XLEN-6){1'b0}}, trap_o.cause[3:0], 2'b00};
        else
            trap_pc_o = vec_base;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the CSR file testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_csr_file
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_csr_file > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: pass message not found in $LOG"
    exit 1
fi

/* include/csr_tb_tasks.svh */
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

// ----------------------------------------
// Helpers
// ----------------------------------------
// Move to the drive point of the next cycle
task automatic step;
    @(posedge clk_i);
    #DRIVE_DLY;
endtask

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
        $display("[FAIL] time %0t: %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
        fail_run();
    end
endtask

// One CSR request for one cycle, returns the old value read
task automatic csr_cycle(input logic [11:0] addr, input csr_op_e op, input logic use_imm,
                         input logic [4:0] imm, input logic [31:0] rs1,
                         output logic [31:0] rdata);
    csr_req_i.valid   = 1'b1;
    csr_req_i.addr    = addr;
    csr_req_i.op      = op;
    csr_req_i.use_imm = use_imm;
    csr_req_i.imm     = imm;
    csr_req_i.rs1     = rs1;
    #SAMPLE_DLY;
    rdata = csr_rdata_o;
    step();
    csr_req_i = '0;
endtask

task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    csr_cycle(addr, CSR_OP_WRITE, 1'b0, 5'd0, data, unused_rd);
endtask

task automatic expect_csr(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    csr_cycle(addr, CSR_OP_NONE, 1'b0, 5'd0, 32'd0, rdata);
    check_val(name, exp, rdata);
endtask

// Expected value after an access, per the CSR instruction rules
function automatic logic [31:0] rmw_result(input logic [31:0] old, input csr_op_e op,
                                           input logic [31:0] operand);
    case (op)
        CSR_OP_WRITE: return operand;
        CSR_OP_SET:   return old | operand;
        CSR_OP_CLEAR: return old & ~operand;
        default:      return old;
    endcase
endfunction

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic test_reset_values;
    mstatus_t ms;
    ms     = '0;
    ms.mie = 1'b1;
    ms.mpp = PRIV_M;
    expect_csr("mstatus", CSR_MSTATUS, ms);
    expect_csr("mie", CSR_MIE, 32'd0);
    expect_csr("mepc", CSR_MEPC, 32'd0);
    expect_csr("mcause", CSR_MCAUSE, 32'd0);
    expect_csr("mtval", CSR_MTVAL, 32'd0);
    check_val("priv_o", 32'(PRIV_M), 32'(priv_o));
    expect_csr("mhartid", CSR_MHARTID, 32'(TB_HART_ID));
endtask

// Write, set, clear with rs1 then imm, then a plain read access
task automatic test_rmw(input string name, input logic [11:0] addr);
    logic [31:0] model;
    logic [31:0] rdata;
    logic [31:0] rs1;
    logic [31:0] rnd;
    logic [31:0] operand;
    logic [4:0]  imm;
    logic        use_imm;
    csr_op_e     op;
    // Both registers come out of reset at zero
    model = 32'd0;
    for (int i = 0; i < 7; i++)
    begin
        rnd = $urandom;
        rs1 = $urandom;
        imm = rnd[4:0];
        case (i % 3)
            0:       op = CSR_OP_WRITE;
            1:       op = CSR_OP_SET;
            default: op = CSR_OP_CLEAR;
        endcase
        if (i == 6)
            op = CSR_OP_NONE;
        use_imm = (i >= 3) && (i < 6);
        operand = use_imm ? {27'd0, imm} : rs1;
        csr_cycle(addr, op, use_imm, imm, rs1, rdata);
        check_val(name, model, rdata);
        model = rmw_result(model, op, operand);
    end
    expect_csr(name, addr, model);
endtask

task automatic test_read_only;
    csr_write(CSR_MVENDORID, $urandom);
    expect_csr("mvendorid", CSR_MVENDORID, 32'd0);
endtask

task automatic test_interrupts;
    logic [31:0] base;
    logic [31:0] pc;
    mstatus_t    ms;
    base = $urandom & 32'hFFFF_FF00;
    pc   = $urandom & 32'hFFFF_FFFC;
    // Enable external, timer and software, vectored mode
    csr_write(CSR_MIE, (32'd1 << 11) | (32'd1 << 7) | (32'd1 << 3));
    csr_write(CSR_MTVEC, base | 32'd1);
    pc_i  = pc;
    irq_i = 3'b111;
    #SAMPLE_DLY;
    check_val("trap_o", 32'd1, 32'(trap_o));
    // External wins, code 11 lands at base + 44
    check_val("trap_pc_o", base + 32'd44, trap_pc_o);
    step();
    irq_i = '0;
    expect_csr("mcause", CSR_MCAUSE, 32'h8000_000B);
    expect_csr("mepc", CSR_MEPC, pc);
    ms      = '0;
    ms.mpp  = PRIV_M;
    ms.mpie = 1'b1;
    expect_csr("mstatus", CSR_MSTATUS, ms);

    // MIE now clear in Machine mode, lines are masked
    irq_i = 3'b111;
    #SAMPLE_DLY;
    check_val("trap_o", 32'd0, 32'(trap_o));
    step();
    irq_i = '0;

    // Software line disabled, pending view lags the lines by one edge
    csr_write(CSR_MIE, (32'd1 << 11) | (32'd1 << 7));
    irq_i = 3'b111;
    expect_csr("mip", CSR_MIP, 32'd0);
    expect_csr("mip", CSR_MIP, (32'd1 << 11) | (32'd1 << 7));
    irq_i = '0;
endtask

task automatic test_exceptions_mret;
    logic [31:0] base;
    logic [31:0] pc;
    logic [31:0] tval;
    mstatus_t    ms;
    base = $urandom & 32'hFFFF_FF00;
    csr_write(CSR_MTVEC, base | 32'd1);

    // Cause 5 carries a trap value, vectored mode still uses base
    pc          = $urandom & 32'hFFFF_FFFC;
    tval        = $urandom;
    pc_i        = pc;
    exc_i.valid = 1'b1;
    exc_i.cause = 4'd5;
    exc_i.tval  = tval;
    #SAMPLE_DLY;
    check_val("trap_o", 32'd1, 32'(trap_o));
    check_val("trap_pc_o", base, trap_pc_o);
    step();
    exc_i = '0;
    expect_csr("mcause", CSR_MCAUSE, 32'd5);
    expect_csr("mtval", CSR_MTVAL, tval);
    expect_csr("mepc", CSR_MEPC, pc);

    // Cause 2 in direct mode, mtval keeps the old value
    csr_write(CSR_MTVEC, base);
    pc          = $urandom & 32'hFFFF_FFFC;
    pc_i        = pc;
    exc_i.valid = 1'b1;
    exc_i.cause = 4'd2;
    exc_i.tval  = ~tval;
    #SAMPLE_DLY;
    check_val("trap_pc_o", base, trap_pc_o);
    step();
    exc_i = '0;
    expect_csr("mcause", CSR_MCAUSE, 32'd2);
    expect_csr("mtval", CSR_MTVAL, tval);

    // Return to User with MPIE set
    ms      = '0;
    ms.mpie = 1'b1;
    ms.mpp  = PRIV_U;
    csr_write(CSR_MSTATUS, ms);
    mret_i = 1'b1;
    #SAMPLE_DLY;
    check_val("mret_pc_o", pc, mret_pc_o);
    step();
    mret_i = 1'b0;
    check_val("priv_o", 32'(PRIV_U), 32'(priv_o));
    ms.mie = 1'b1;
    expect_csr("mstatus", CSR_MSTATUS, ms);

    // User mode ignores MIE for Machine interrupts
    ms.mie = 1'b0;
    csr_write(CSR_MSTATUS, ms);
    irq_i.ext = 1'b1;
    #SAMPLE_DLY;
    check_val("trap_o", 32'd1, 32'(trap_o));
    step();
    irq_i = '0;
    check_val("priv_o", 32'(PRIV_M), 32'(priv_o));
    expect_csr("mcause", CSR_MCAUSE, 32'h8000_000B);
    // MPP holds User, both enables clear
    expect_csr("mstatus", CSR_MSTATUS, 32'd0);
    // Interrupt entry leaves the trap value alone
    expect_csr("mtval", CSR_MTVAL, tval);
endtask

task automatic test_cycle_counter;
    logic [31:0]  first;
    logic [31:0]  second;
    logic [31:0]  hi_val;
    logic [31:0]  lo_before;
    logic [31:0]  unused_rd;
    int unsigned  gap;
    gap = 4 + ($urandom % 8);
    csr_cycle(CSR_MCYCLE, CSR_OP_NONE, 1'b0, 5'd0, 32'd0, first);
    repeat (gap - 1) step();
    csr_cycle(CSR_MCYCLE, CSR_OP_NONE, 1'b0, 5'd0, 32'd0, second);
    check_val("mcycle delta", gap, second - first);

    // Write edge holds the count, the edges around it count
    hi_val = $urandom;
    csr_cycle(CSR_MCYCLE, CSR_OP_NONE, 1'b0, 5'd0, 32'd0, lo_before);
    csr_cycle(CSR_MCYCLEH, CSR_OP_WRITE, 1'b0, 5'd0, hi_val, unused_rd);
    expect_csr("cycleh", CSR_CYCLEH, hi_val);
    expect_csr("mcycle", CSR_MCYCLE, lo_before + 32'd2);
endtask

`endif

/* sim/tb_csr_file.sv */
`default_nettype none

module tb_csr_file
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------
    // Bench constants
    // ----------------------------------------
    localparam int          CLK_PERIOD      = 100;
    // Inputs change this long after the rising edge
    localparam int          DRIVE_DLY       = 10;
    // Combinational outputs are read this long after a drive
    localparam int          SAMPLE_DLY      = 5;
    localparam int          RESET_CYCLES    = 3;
    // Tests need well under 150 cycles
    localparam int          WATCHDOG_CYCLES = 400;
    localparam int unsigned TB_HART_ID      = 5;
    localparam logic [31:0] RAND_SEED       = 32'h2955bee5;

    logic            clk_i;
    logic            rst_i;
    csr_req_t        csr_req_i;
    irq_lines_t      irq_i;
    exc_req_t        exc_i;
    logic [XLEN-1:0] pc_i;
    logic            mret_i;
    logic [XLEN-1:0] csr_rdata_o;
    logic            trap_o;
    logic [XLEN-1:0] trap_pc_o;
    logic [XLEN-1:0] mret_pc_o;
    priv_e           priv_o;

    csr_file_top #(
        .HART_ID     (TB_HART_ID)
    ) i_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .csr_req_i   (csr_req_i),
        .irq_i       (irq_i),
        .exc_i       (exc_i),
        .pc_i        (pc_i),
        .mret_i      (mret_i),
        .csr_rdata_o (csr_rdata_o),
        .trap_o      (trap_o),
        .trap_pc_o   (trap_pc_o),
        .mret_pc_o   (mret_pc_o),
        .priv_o      (priv_o)
    );

    // 100 ns clock
    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Hung run guard
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    // Final failure report, ends the run
    task automatic fail_run;
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin
        void'($urandom(RAND_SEED));
        rst_i     = 1'b1;
        csr_req_i = '0;
        irq_i     = '0;
        exc_i     = '0;
        pc_i      = '0;
        mret_i    = 1'b0;
        // Hold reset over three edges, release at a drive point
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;

        test_reset_values();
        test_rmw("mscratch", CSR_MSCRATCH);
        test_rmw("mtvec", CSR_MTVEC);
        test_read_only();
        test_interrupts();
        test_exceptions_mret();
        test_cycle_counter();

        $display("SIMULATION PASSED");
        $finish;
    end

    // Tasks see the bench signals declared above
    `include "csr_tb_tasks.svh"

endmodule

`default_nettype wire
